/* sources.f */
+incdir+design
design/cpu_pkg.sv
design/cpu_control.sv
design/program_counter.sv
design/inst_decode.sv
design/reg_file.sv
design/alu.sv
design/cpu_core.sv
sim/clock_gen.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module cpu_tb \
	--Mdir obj_dir -o cpu_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/cpu_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* sim/cpu_tb.sv */
`include "cpu_settings.svh"

module cpu_tb
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMEM_WORDS = 1 << `CPU_IMEM_AW;
	localparam int DMEM_WORDS = 1 << `CPU_DMEM_AW;
	localparam int TIMEOUT = 400;

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        overflow;
	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] dmem [0:DMEM_WORDS-1];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int          ptr;
	int          next_slot = 1;
	int          seed = 64;

	clock_gen clock0 (.clk, .reset);

	cpu_core dut0 (
		.clk, .reset, .imem_addr, .imem_rdata, .dmem_addr, .dmem_wdata, .dmem_we,
		.dmem_rdata, .overflow
	);

	// Both memories answer combinationally, as the core expects.
	assign imem_rdata = imem[imem_addr[`CPU_IMEM_AW+1:2]];
	assign dmem_rdata = dmem[dmem_addr[`CPU_DMEM_AW+1:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[`CPU_DMEM_AW+1:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] enc_imm(opcode_t op, logic [4:0] rt, logic [4:0] ra,
			logic [14:0] i15);
		return {1'b0, op, rt, ra, i15};
	endfunction

	function automatic logic [31:0] enc_base(sub_op_t s, logic [4:0] rt, logic [4:0] ra,
			logic [4:0] rb);
		return {1'b0, TY_BASE, rt, ra, rb, 5'd0, s};
	endfunction

	function automatic logic [31:0] model_imm(opcode_t op, logic [31:0] a, logic [14:0] i15);
		logic [31:0] sx;
		logic [31:0] zx;
		sx = {{17{i15[14]}}, i15};
		zx = {17'd0, i15};
		case (op)
			ADDI:    return a + sx;
			SUBRI:   return sx - a;
			ANDI:    return a & zx;
			ORI:     return a | zx;
			XORI:    return a ^ zx;
			SLTI:    return (a < sx) ? 32'd1 : 32'd0;
			SLTSI:   return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] model_base(sub_op_t s, logic [31:0] a, logic [31:0] b,
			logic [4:0] sh);
		case (s)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SEB:     return {{24{a[7]}}, a[7:0]};
			SEH:     return {{16{a[15]}}, a[15:0]};
			SLT:     return (a < b) ? 32'd1 : 32'd0;
			SLTS:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SRL:     return a >> b[4:0];
			SLL:     return a << b[4:0];
			SRLI:    return a >> sh;
			SLLI:    return a << sh;
			ROTRI:   return (sh == 5'd0) ? a : ((a >> sh) | (a << (6'd32 - sh)));
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] pc_of(int idx);
		logic [31:0] rv;
		rv = `CPU_RESET_VECTOR;
		return {rv[31:`CPU_IMEM_AW+2], idx[`CPU_IMEM_AW-1:0], 2'b00};
	endfunction

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic emit(logic [31:0] word);
		imem[ptr] = word;
		ptr = (ptr + 1) % IMEM_WORDS;
	endtask

	// New code goes just ahead of the running instruction, past the idle filler.
	task automatic start_program();
		ptr = (int'(imem_addr[`CPU_IMEM_AW+1:2]) + 2) % IMEM_WORDS;
		exp_addr.delete();
		exp_data.delete();
	endtask

	// Builds a full word from three OR-immediates and two shifts.
	task automatic load_const(logic [4:0] r, logic [31:0] v);
		emit(enc_imm(ORI, r, 5'd0, {1'b0, v[31:18]}));
		emit(enc_base(SLLI, r, r, 5'd15));
		emit(enc_imm(ORI, r, r, v[17:3]));
		emit(enc_base(SLLI, r, r, 5'd3));
		emit(enc_imm(ORI, r, r, {12'd0, v[2:0]}));
	endtask

	task automatic store_at(logic [4:0] r, logic [4:0] base, logic [31:0] base_val,
			logic [14:0] off, logic [31:0] value);
		emit(enc_imm(SWI, r, base, off));
		exp_addr.push_back(base_val + {{15{off[14]}}, off, 2'b00});
		exp_data.push_back(value);
	endtask

	task automatic store(logic [4:0] r, logic [31:0] value);
		store_at(r, 5'd0, 32'd0, 15'(next_slot), value);
		next_slot++;
	endtask

	task automatic wait_store(string name);
		int n;
		n = 0;
		@(negedge clk);
		while (!dmem_we && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!dmem_we) begin
			$display("Timed out in %s while waiting for a store from the core.", name);
			$display("TEST FAILED");
			$fatal(1, "No store pulse.");
		end
	endtask

	task automatic drain_stores(string name);
		while (exp_addr.size() > 0) begin
			wait_store(name);
			check({name, " addr"}, exp_addr.pop_front(), dmem_addr);
			check({name, " data"}, exp_data.pop_front(), dmem_wdata);
		end
	endtask

	task automatic wait_pc(logic [31:0] target, string name);
		int n;
		n = 0;
		@(negedge clk);
		while (imem_addr !== target && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (imem_addr !== target) begin
			$display("Timed out in %s while waiting for the next fetch address.", name);
			$display("TEST FAILED");
			$fatal(1, "Fetch address stalled.");
		end
	endtask

	task automatic test_reset();
		int n;
		n = 0;
		@(negedge clk);
		while (reset && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (reset) begin
			$display("Reset never went low.");
			$display("TEST FAILED");
			$fatal(1, "Reset stuck.");
		end
		@(negedge clk);
		check("reset pc", `CPU_RESET_VECTOR, imem_addr);
		check("reset dmem_we", 32'd0, {31'd0, dmem_we});
		check("reset overflow", 32'd0, {31'd0, overflow});
		wait_pc(`CPU_RESET_VECTOR + 32'd4, "pc step");
		// The next step comes exactly five cycles after the first.
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check("pc hold", `CPU_RESET_VECTOR + 32'd4, imem_addr);
		end
		@(negedge clk);
		check("pc step", `CPU_RESET_VECTOR + 32'd8, imem_addr);
	endtask

	task automatic test_imm_ops();
		opcode_t ops [7];
		logic [31:0] a;
		logic [14:0] i15;
		ops = '{ADDI, SUBRI, ANDI, ORI, XORI, SLTI, SLTSI};
		for (int round = 0; round < 2; round++) begin
			start_program();
			a = $random(seed);
			load_const(5'd1, a);
			for (int i = 0; i < 7; i++) begin
				i15 = 15'($random(seed));
				i15[14] = ((i % 2) == round); // Half the immediates are negative.
				emit(enc_imm(ops[i], 5'd2, 5'd1, i15));
				store(5'd2, model_imm(ops[i], a, i15));
			end
			drain_stores("imm ops");
		end
	endtask

	task automatic test_base_ops();
		sub_op_t subs [12];
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		subs = '{ADD, SUB, AND, OR, XOR, SEB, SEH, SRL, SLL, SRLI, SLLI, ROTRI};
		start_program();
		a = $random(seed);
		b = $random(seed);
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int i = 0; i < 12; i++) begin
			sh = 5'($random(seed));
			if (subs[i] == SRLI || subs[i] == SLLI || subs[i] == ROTRI) begin
				emit(enc_base(subs[i], 5'd3, 5'd1, sh));
			end else begin
				emit(enc_base(subs[i], 5'd3, 5'd1, 5'd2));
			end
			store(5'd3, model_base(subs[i], a, b, sh));
		end
		drain_stores("base ops");
	endtask

	task automatic test_compare();
		logic [31:0] neg;
		logic [31:0] pos;
		start_program();
		neg = $random(seed) | 32'h8000_0000;
		pos = $random(seed) & 32'h7fff_ffff;
		load_const(5'd1, neg);
		load_const(5'd2, pos);
		// An unsigned compare sees the negative value as the larger one.
		emit(enc_base(SLT, 5'd3, 5'd1, 5'd2));
		store(5'd3, 32'd0);
		emit(enc_base(SLTS, 5'd3, 5'd1, 5'd2));
		store(5'd3, 32'd1);
		emit(enc_base(SLT, 5'd3, 5'd2, 5'd1));
		store(5'd3, 32'd1);
		emit(enc_base(SLTS, 5'd3, 5'd2, 5'd1));
		store(5'd3, 32'd0);
		drain_stores("slt vs slts");
	endtask

	task automatic test_overflow();
		int idx_add;
		start_program();
		load_const(5'd1, 32'h7fff_ffff);
		load_const(5'd5, 32'h8000_0000);
		emit(enc_imm(ORI, 5'd2, 5'd0, 15'd1));
		idx_add = ptr;
		emit(enc_base(ADD, 5'd3, 5'd1, 5'd2));
		emit(enc_base(SUB, 5'd4, 5'd5, 5'd2));
		emit(enc_base(ADD, 5'd6, 5'd2, 5'd2));
		store(5'd3, 32'h8000_0000);
		store(5'd4, 32'h7fff_ffff);
		store(5'd6, 32'd2);
		// The flag is sampled between writeback and the next execute.
		wait_pc(pc_of(idx_add + 1), "overflow add");
		check("overflow add", 32'd1, {31'd0, overflow});
		wait_pc(pc_of(idx_add + 2), "overflow sub");
		check("overflow sub", 32'd1, {31'd0, overflow});
		wait_pc(pc_of(idx_add + 3), "overflow clear");
		check("overflow clear", 32'd0, {31'd0, overflow});
		drain_stores("overflow");
	endtask

	task automatic test_load_store();
		for (int i = 200; i < 204; i++) begin
			dmem[i] = $random(seed);
		end
		start_program();
		emit(enc_imm(LWI, 5'd7, 5'd0, 15'd200));
		store(5'd7, dmem[200]);
		emit(enc_imm(ORI, 5'd8, 5'd0, 15'd8));
		emit(enc_imm(LWI, 5'd9, 5'd8, 15'd200)); // Byte address 808 is word 202.
		store(5'd9, dmem[202]);
		load_const(5'd10, 32'd840);
		emit(enc_imm(LWI, 5'd11, 5'd10, 15'h7ff7)); // Offset -9 words reaches word 201.
		store_at(5'd11, 5'd8, 32'd8, 15'd150, dmem[201]);
		drain_stores("load store");
	endtask

	initial begin
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = {1'b0, 6'b111111, 15'd0, 10'(i)}; // An unknown opcode writes nothing.
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = {16'(i), ~16'(i)};
		end
		test_reset();
		test_imm_ops();
		test_base_ops();
		test_compare();
		test_overflow();
		test_load_store();
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim/clock_gen.sv */
module clock_gen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	end

	always #20 clk = ~clk; // 40 ns period.

endmodule

/* design/cpu_core.sv */
module cpu_core
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  logic [31:0] dmem_rdata,
	output logic        overflow
);

	logic        fetch_en;
	logic        read_en;
	logic        execute_en;
	logic        mem_en;
	logic        wb_en;
	opcode_t     opcode;
	sub_op_t     sub_op;
	logic [4:0]  ra;
	logic [4:0]  rb;
	logic [4:0]  rt;
	logic [31:0] imm;
	logic        use_imm;
	logic        writes_reg;
	logic        is_load;
	logic        is_store;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] store_data;
	logic [31:0] alu_result;
	logic [31:0] load_data;
	logic [31:0] wb_data;

	cpu_control control0 (.clk, .reset, .fetch_en, .read_en, .execute_en, .mem_en, .wb_en);

	program_counter pc0 (.clk, .reset, .wb_en, .pc(imem_addr));

	inst_decode decode0 (
		.clk, .reset, .fetch_en, .imem_rdata, .opcode, .sub_op, .ra, .rb, .rt,
		.imm, .use_imm, .writes_reg, .is_load, .is_store
	);

	reg_file regs0 (
		.clk, .reset, .read_en, .wb_en, .writes_reg, .ra, .rb, .rt,
		.wdata(wb_data), .src_a, .src_b, .store_data
	);

	alu alu0 (
		.clk, .reset, .execute_en, .opcode, .sub_op, .src_a, .src_b, .imm, .use_imm,
		.result(alu_result), .overflow
	);

	// The data memory answers in the same cycle, so the word is caught in the memory state.
	always_ff @(posedge clk) begin
		if (mem_en) begin
			load_data <= dmem_rdata;
		end
	end

	assign wb_data    = is_load ? load_data : alu_result;
	assign dmem_addr  = alu_result;
	assign dmem_wdata = store_data;
	assign dmem_we    = mem_en & is_store; // One cycle, fourth of the instruction.

endmodule

/* design/alu.sv */
module alu
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        execute_en,
	input  opcode_t     opcode,
	input  sub_op_t     sub_op,
	input  logic [31:0] src_a,
	input  logic [31:0] src_b,
	input  logic [31:0] imm,
	input  logic        use_imm,
	output logic [31:0] result,
	output logic        overflow
);

	logic [31:0] op_b;
	logic [4:0]  shamt;
	logic [32:0] sum_ab;
	logic [32:0] diff_ab;
	logic [32:0] diff_ba;
	logic [63:0] rotate;
	logic [31:0] result_next;
	logic        ovf_next;

	// Returns the overflow flag above the 32-bit sum.
	// Overflow is the carry into bit 31 against the carry out of it.
	function automatic logic [32:0] add_chk(
		input logic [31:0] x,
		input logic [31:0] y,
		input logic        sub
	);
		logic [31:0] yy;
		logic [31:0] low;
		logic [1:0]  top;
		yy  = sub ? ~y : y;
		low = {1'b0, x[30:0]} + {1'b0, yy[30:0]} + {31'd0, sub};
		top = {1'b0, x[31]} + {1'b0, yy[31]} + {1'b0, low[31]};
		return {low[31] ^ top[1], top[0], low[30:0]};
	endfunction

	assign op_b    = use_imm ? imm : src_b;
	assign shamt   = op_b[4:0];
	assign sum_ab  = add_chk(src_a, op_b, 1'b0);
	assign diff_ab = add_chk(src_a, op_b, 1'b1);
	assign diff_ba = add_chk(op_b, src_a, 1'b1); // SUBRI takes the operands reversed.
	assign rotate  = {src_a, src_a} >> shamt;

	always_comb begin
		result_next = '0;
		ovf_next    = 1'b0;
		case (opcode)
			TY_BASE: begin
				case (sub_op)
					ADD: begin
						{ovf_next, result_next} = sum_ab;
					end
					SUB: begin
						{ovf_next, result_next} = diff_ab;
					end
					AND: result_next = src_a & op_b;
					OR:  result_next = src_a | op_b;
					XOR: result_next = src_a ^ op_b;
					SEB: result_next = {{24{src_a[7]}}, src_a[7:0]};
					SEH: result_next = {{16{src_a[15]}}, src_a[15:0]};
					SLT: result_next = {31'd0, src_a < op_b};
					SLTS: begin
						result_next = {31'd0, $signed(src_a) < $signed(op_b)};
					end
					SRL, SRLI: result_next = src_a >> shamt;
					SLL, SLLI: result_next = src_a << shamt;
					ROTRI: result_next = rotate[31:0];
					default: result_next = '0;
				endcase
			end
			ADDI, LWI, SWI: begin
				{ovf_next, result_next} = sum_ab; // Loads and stores add the offset.
			end
			SUBRI: begin
				{ovf_next, result_next} = diff_ba;
			end
			ANDI: result_next = src_a & op_b;
			ORI:  result_next = src_a | op_b;
			XORI: result_next = src_a ^ op_b;
			SLTI: result_next = {31'd0, src_a < op_b};
			SLTSI: begin
				result_next = {31'd0, $signed(src_a) < $signed(op_b)};
			end
			default: begin
				result_next = '0;
			end
		endcase
	end

	// The flag holds until the next instruction leaves execute.
	always_ff @(posedge clk) begin
		if (reset) begin
			overflow <= 1'b0;
		end else if (execute_en) begin
			overflow <= ovf_next;
		end
	end

	always_ff @(posedge clk) begin
		if (execute_en) begin
			result <= result_next;
		end
	end

endmodule

/* design/reg_file.sv */
module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        read_en,
	input  logic        wb_en,
	input  logic        writes_reg,
	input  logic [4:0]  ra,
	input  logic [4:0]  rb,
	input  logic [4:0]  rt,
	input  logic [31:0] wdata,
	output logic [31:0] src_a,
	output logic [31:0] src_b,
	output logic [31:0] store_data
);

	logic [31:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && writes_reg) begin
			regs[rt] <= wdata;
		end
	end

	// Reads and the write fall in different states, so no bypass is needed.
	always_ff @(posedge clk) begin
		if (read_en) begin
			src_a      <= regs[ra];
			src_b      <= regs[rb];
			store_data <= regs[rt]; // SWI stores the rt register.
		end
	end

endmodule

/* design/inst_decode.sv */
module inst_decode
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        fetch_en,
	input  logic [31:0] imem_rdata,
	output opcode_t     opcode,
	output sub_op_t     sub_op,
	output logic [4:0]  ra,
	output logic [4:0]  rb,
	output logic [4:0]  rt,
	output logic [31:0] imm,
	output logic        use_imm,
	output logic        writes_reg,
	output logic        is_load,
	output logic        is_store
);

	instr_t ir;

	// A zero word is no known opcode, so a cleared register writes nothing back.
	always_ff @(posedge clk) begin
		if (reset) begin
			ir <= '0;
		end else if (fetch_en) begin
			ir <= imem_rdata;
		end
	end

	// Register fields sit at the same place in both formats.
	assign opcode = ir.base.opcode;
	assign sub_op = ir.base.sub_op;
	assign rt     = ir.base.rt;
	assign ra     = ir.base.ra;
	assign rb     = ir.base.rb;

	always_comb begin
		imm        = {{17{ir.imm.imm15[14]}}, ir.imm.imm15};
		use_imm    = 1'b1;
		writes_reg = 1'b1;
		is_load    = 1'b0;
		is_store   = 1'b0;
		case (ir.imm.opcode)
			TY_BASE: begin
				imm = {27'd0, ir.base.rb}; // Shift amount of the immediate shifts.
				use_imm = (ir.base.sub_op == SRLI) || (ir.base.sub_op == SLLI) ||
					(ir.base.sub_op == ROTRI);
				case (ir.base.sub_op)
					ADD, SUB, AND, OR, XOR, SEB, SEH, SLT, SLTS,
					SRL, SLL, SRLI, SLLI, ROTRI: begin
						writes_reg = 1'b1;
					end
					default: begin
						writes_reg = 1'b0;
					end
				endcase
			end
			ADDI, SUBRI, SLTI, SLTSI: begin
			end
			ANDI, ORI, XORI: begin
				imm = {17'd0, ir.imm.imm15}; // Logic operations take it unsigned.
			end
			LWI: begin
				imm     = {{15{ir.imm.imm15[14]}}, ir.imm.imm15, 2'b00};
				is_load = 1'b1;
			end
			SWI: begin
				imm        = {{15{ir.imm.imm15[14]}}, ir.imm.imm15, 2'b00};
				writes_reg = 1'b0;
				is_store   = 1'b1;
			end
			default: begin
				writes_reg = 1'b0;
			end
		endcase
	end

endmodule

/* design/program_counter.sv */
`include "cpu_settings.svh"

module program_counter (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_en,
	output logic [31:0] pc
);

	// Byte-address bits that belong to the instruction memory window.
	localparam int WRAP_W = `CPU_IMEM_AW + 2;

	logic [31:0] pc_step;

	assign pc_step = pc + `CPU_WORD_BYTES;

	// The step wraps inside the memory window and leaves the upper bits alone.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `CPU_RESET_VECTOR;
		end else if (wb_en) begin
			pc <= {pc[31:WRAP_W], pc_step[WRAP_W-1:0]};
		end
	end

endmodule

/* design/cpu_control.sv */
module cpu_control
	import cpu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic fetch_en,
	output logic read_en,
	output logic execute_en,
	output logic mem_en,
	output logic wb_en
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Every instruction walks all five states, whether it touches memory or not.
	always_comb begin
		case (state)
			FETCH: begin
				next_state = DECODE;
			end
			DECODE: begin
				next_state = EXECUTE;
			end
			EXECUTE: begin
				next_state = MEMORY;
			end
			MEMORY: begin
				next_state = WRITEBACK;
			end
			WRITEBACK: begin
				next_state = FETCH;
			end
			default: begin
				next_state = FETCH; // Recover from an unused encoding.
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= next_state;
		end
	end

	// One strobe per state, each high for exactly one cycle.
	assign fetch_en   = (state == FETCH);
	assign read_en    = (state == DECODE);
	assign execute_en = (state == EXECUTE);
	assign mem_en     = (state == MEMORY);
	assign wb_en      = (state == WRITEBACK);

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

	typedef enum logic [5:0] {
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_BASE = 6'b100000,
		ADDI    = 6'b101000,
		SUBRI   = 6'b101001,
		ANDI    = 6'b101010,
		XORI    = 6'b101011,
		ORI     = 6'b101100,
		SLTI    = 6'b101110,
		SLTSI   = 6'b101111
	} opcode_t;

	// Sub-operations of the base type, in the low five bits of the word.
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLT   = 5'b00110,
		SLTS  = 5'b00111,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011,
		SLL   = 5'b01100,
		SRL   = 5'b01101,
		SEB   = 5'b10000,
		SEH   = 5'b10001
	} sub_op_t;

	typedef struct packed {
		logic       spare_hi;
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb; // Also the shift amount of the immediate shifts.
		logic [4:0] spare_lo;
		sub_op_t    sub_op;
	} base_fmt_t;

	typedef struct packed {
		logic        spare_hi;
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm15;
	} imm_fmt_t;

	typedef union packed {
		base_fmt_t base;
		imm_fmt_t  imm;
	} instr_t;

	typedef enum logic [2:0] {
		FETCH     = 3'd0,
		DECODE    = 3'd1,
		EXECUTE   = 3'd2,
		MEMORY    = 3'd3,
		WRITEBACK = 3'd4
	} ctrl_state_t;

endpackage

/* design/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Address of the first instruction fetched after reset.
`define CPU_RESET_VECTOR 32'h0000_0000

// Word-address width of the instruction memory.
// The program counter wraps inside this window.
`define CPU_IMEM_AW 10

// Word-address width of the data memory.
`define CPU_DMEM_AW 10

// Both memories hold 32-bit words, so a byte address carries two extra low bits.
`define CPU_WORD_BYTES 4

`endif
